/* Makefile */
# Verilator build and run of the core testbench

TOP = tb_core

.PHONY: help test clean

help:
	@echo "make test   build with Verilator and run the testbench"
	@echo "make clean  remove the build directory"
	@echo "make help   show this list"

test:
	verilator --binary --timing --assert -f filelist.f --top-module $(TOP) -o $(TOP)
	@out=$$(./obj_dir/$(TOP)); echo "$$out"; echo "$$out" | grep -qx "NO ERRORS"

clean:
	rm -rf obj_dir

/* filelist.f */
logic/tlcs_pkg.sv
logic/op_fetch.sv
logic/insn_decode.sv
logic/reg_bank.sv
logic/move_unit.sv
logic/tlcs_core.sv
testbench/tb_core_properties.sv
testbench/tb_core.sv

/* logic/insn_decode.sv */
// Decode FSM. Consumes one to three bytes per step from the fetch window and
// issues registered move commands for NOP, LD R,#, the two-operand prefix and
// the register and immediate forms behind it. Word and long immediates are
// completed in the fill phase. insn_done pulses with each finished instruction.

`timescale 1ns/100ps
`default_nettype none

module insn_decode (
    input  wire logic         clk,
    input  wire logic         rst,
    input  wire logic [31:0]  op,
    input  wire logic         op_ok,
    output logic [1:0]        consumed,
    output tlcs_pkg::alu_cmd_t cmd,
    output logic              insn_done
);

    import tlcs_pkg::*;

    op_phase_e   phase;
    op_phase_e   nx_phase;
    width_e      width_q;  // latched zz
    width_e      nx_width;
    reg_code_t   dst_q;    // pending destination, R of the prefix
    reg_code_t   nx_dst;
    logic [31:0] imm_q;    // partial immediate
    logic [31:0] nx_imm;
    alu_cmd_t    nx_cmd;
    logic        nx_done;

    function automatic alu_cmd_t move_cmd(input logic [31:0] imm, input logic use_imm,
                                          input reg_code_t src, input reg_code_t dst,
                                          input width_e w);
        alu_cmd_t c;
        c.op      = ALU_MOVE;
        c.imm     = imm;
        c.use_imm = use_imm;
        c.src     = src;
        c.dst     = dst;
        c.width   = w;
        c.valid   = 1'b1;
        return c;
    endfunction

    always_comb begin
        nx_phase = phase;
        nx_width = width_q;
        nx_dst   = dst_q;
        nx_imm   = imm_q;
        nx_cmd   = '0;
        nx_done  = 1'b0;
        consumed = 2'd0;
        if (op_ok) begin
            case (phase)
                PH_FETCH: begin
                    casez (op[7:0])
                        8'h00: begin // NOP
                            consumed = 2'd1;
                            nx_done  = 1'b1;
                        end
                        8'b0???_0???: begin // LD R,#
                            nx_width = imm_width(op[6:4]);
                            nx_dst   = short_reg_code(op[2:0], nx_width);
                            nx_imm   = {24'd0, op[15:8]};
                            consumed = 2'd2;
                            if (nx_width == W_BYTE) begin
                                nx_cmd  = move_cmd(nx_imm, 1'b1, nx_dst, nx_dst, nx_width);
                                nx_done = 1'b1;
                            end else begin
                                nx_phase = PH_FILL_IMM;
                            end
                        end
                        8'b11??_1???: begin
                            consumed = 2'd1;
                            if (op[5:4] != 2'b11) begin // two-operand prefix
                                nx_width = width_e'(op[5:4]);
                                nx_dst   = short_reg_code(op[2:0], nx_width);
                                nx_phase = PH_EXEC;
                            end else begin
                                nx_done = 1'b1;
                            end
                        end
                        default: begin // unknown, skipped
                            consumed = 2'd1;
                            nx_done  = 1'b1;
                        end
                    endcase
                end
                PH_EXEC: begin
                    nx_phase = PH_FETCH;
                    consumed = 2'd1;
                    nx_done  = 1'b1;
                    casez (op[7:0])
                        8'b1000_1???: // LD r,R
                            nx_cmd = move_cmd(imm_q, 1'b0, dst_q,
                                              short_reg_code(op[2:0], width_q), width_q);
                        8'b1001_1???: // LD R,r
                            nx_cmd = move_cmd(imm_q, 1'b0, short_reg_code(op[2:0], width_q),
                                              dst_q, width_q);
                        8'b1010_1???: // LD R,n small immediate
                            nx_cmd = move_cmd({29'd0, op[2:0]}, 1'b1, dst_q, dst_q, width_q);
                        8'b0000_0011: begin // LD R,#
                            consumed = 2'd2;
                            nx_imm   = {24'd0, op[15:8]};
                            if (width_q == W_BYTE) begin
                                nx_cmd = move_cmd(nx_imm, 1'b1, dst_q, dst_q, width_q);
                            end else begin
                                nx_phase = PH_FILL_IMM;
                                nx_done  = 1'b0;
                            end
                        end
                        default: ;
                    endcase
                end
                PH_FILL_IMM: begin
                    nx_phase = PH_FETCH;
                    nx_done  = 1'b1;
                    if (width_q == W_WORD) begin
                        nx_imm   = {16'd0, op[7:0], imm_q[7:0]};
                        consumed = 2'd1;
                    end else begin
                        nx_imm   = {op[23:0], imm_q[7:0]};
                        consumed = 2'd3;
                    end
                    nx_cmd = move_cmd(nx_imm, 1'b1, dst_q, dst_q, width_q);
                end
                default: nx_phase = PH_FETCH;
            endcase
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            phase     <= PH_FETCH;
            width_q   <= W_BYTE;
            dst_q     <= 8'he0;
            cmd       <= '0;
            insn_done <= 1'b0;
        end else begin
            phase     <= nx_phase;
            width_q   <= nx_width;
            dst_q     <= nx_dst;
            cmd       <= nx_cmd;
            insn_done <= nx_done;
        end
    end

    always_ff @(posedge clk) begin
        imm_q <= nx_imm;
    end

endmodule

`default_nettype wire

/* logic/move_unit.sv */
// Move datapath. Picks the immediate or the register operand for a command,
// truncates it to the operand width and replicates it over the 32-bit word so
// the bank's lane enables take the right bytes. One cycle, registered.

`timescale 1ns/100ps
`default_nettype none

module move_unit (
    input  wire logic               clk,
    input  wire logic               rst,
    input  wire tlcs_pkg::alu_cmd_t cmd,
    input  wire logic [31:0]        rd_data,
    output tlcs_pkg::wb_t           wb
);

    import tlcs_pkg::*;

    logic [31:0] operand;
    logic [31:0] sized;
    logic        wb_valid;
    reg_code_t   wb_dst;
    logic [31:0] wb_data;
    width_e      wb_width;

    assign operand = cmd.use_imm ? cmd.imm : rd_data;

    always_comb begin
        case (cmd.width)
            W_BYTE:  sized = {4{operand[7:0]}};
            W_WORD:  sized = {2{operand[15:0]}};
            default: sized = operand;
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst)
            wb_valid <= 1'b0;
        else
            wb_valid <= cmd.valid && (cmd.op == ALU_MOVE);
    end

    always_ff @(posedge clk) begin
        wb_dst   <= cmd.dst;
        wb_data  <= sized;
        wb_width <= cmd.width;
    end

    assign wb = '{dst: wb_dst, data: wb_data, width: wb_width, valid: wb_valid};

endmodule

`default_nettype wire

/* logic/op_fetch.sv */
// Instruction fetch. Reads 32-bit words over an AXI4-Lite read master into a
// circular byte queue and presents the four oldest bytes as the opcode window.
// The decoder reports how many bytes it used; op_ok drops for one cycle after
// every removal so the window is never stale.

`timescale 1ns/100ps
`default_nettype none

module op_fetch #(
    parameter int          QUEUE_BYTES = 8,
    parameter logic [31:0] RESET_PC    = 32'h0
) (
    input  wire logic             clk,
    input  wire logic             rst,
    output tlcs_pkg::axi_ar_t     ar,
    output logic                  arvalid,
    input  wire logic             arready,
    input  wire tlcs_pkg::axi_r_t r,
    input  wire logic             rvalid,
    output logic                  rready,
    output logic [31:0]           op,
    output logic                  op_ok,
    input  wire logic [1:0]       consumed
);

    localparam int PW = $clog2(QUEUE_BYTES);
    localparam int CW = PW + 1;

    logic [7:0]    q [QUEUE_BYTES];
    logic [PW-1:0] rd_ptr;
    logic [PW-1:0] wr_ptr;
    logic [CW-1:0] fill;       // bytes queued
    logic [31:0]   fetch_addr;
    logic          pending;    // AR accepted, waiting for R
    logic          hold_valid; // word waiting to enter the queue
    logic [31:0]   hold_data;
    logic          op_mask;
    logic          room;
    logic          r_fire;

    assign room    = fill <= CW'(QUEUE_BYTES - 4);
    assign r_fire  = rvalid && rready;
    assign rready  = !hold_valid;
    assign ar      = '{addr: fetch_addr, prot: 3'b100}; // instruction access
    assign op_ok   = (fill >= CW'(4)) && !op_mask;

    always_comb begin
        for (int i = 0; i < 4; i++) begin
            op[8*i +: 8] = q[rd_ptr + PW'(i)]; // little endian window
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            arvalid    <= 1'b0;
            pending    <= 1'b0;
            hold_valid <= 1'b0;
            fetch_addr <= RESET_PC;
            rd_ptr     <= '0;
            wr_ptr     <= '0;
            fill       <= '0;
            op_mask    <= 1'b0;
        end else begin
            if (arvalid) begin
                if (arready) begin
                    arvalid    <= 1'b0;
                    pending    <= 1'b1;
                    fetch_addr <= fetch_addr + 32'd4;
                end
            end else if (!pending && !hold_valid && room) begin
                arvalid <= 1'b1;
            end
            if (r_fire) begin
                pending    <= 1'b0;
                hold_valid <= 1'b1;
            end else begin
                hold_valid <= 1'b0;
            end
            if (hold_valid)
                wr_ptr <= wr_ptr + PW'(4);
            rd_ptr  <= rd_ptr + PW'(consumed);
            fill    <= fill + (hold_valid ? CW'(4) : CW'(0)) - CW'(consumed);
            op_mask <= consumed != 2'd0;
        end
    end

    always_ff @(posedge clk) begin
        if (r_fire)
            hold_data <= r.data;
        if (hold_valid) begin
            for (int i = 0; i < 4; i++) begin
                q[wr_ptr + PW'(i)] <= hold_data[8*i +: 8];
            end
        end
    end

endmodule

`default_nettype wire

/* logic/reg_bank.sv */
// General register bank. Eight 32-bit registers addressed by byte code E0..FF,
// written in byte lanes from the move unit's write-back. One read port serves
// the source operand, shifted down to the addressed lane; a second port lets
// the testbench observe whole registers.

`timescale 1ns/100ps
`default_nettype none

module reg_bank (
    input  wire logic                clk,
    input  wire logic                rst,
    input  wire tlcs_pkg::reg_code_t rd_code,
    output logic [31:0]              rd_data,
    input  wire tlcs_pkg::wb_t       wb,
    input  wire logic [2:0]          dbg_reg,
    output logic [31:0]              dbg_data
);

    import tlcs_pkg::*;

    logic [31:0] regs [8];
    logic [3:0]  lane_we;
    logic        wr_ok;

    assign wr_ok    = wb.valid && (wb.dst[7:5] == 3'b111);
    assign rd_data  = regs[rd_code[4:2]] >> {rd_code[1:0], 3'b000};
    assign dbg_data = regs[dbg_reg];

    always_comb begin
        case (wb.width)
            W_BYTE:  lane_we = 4'b0001 << wb.dst[1:0];
            W_WORD:  lane_we = 4'b0011 << {wb.dst[1], 1'b0};
            default: lane_we = 4'b1111;
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < 8; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_ok) begin
            for (int b = 0; b < 4; b++) begin
                if (lane_we[b])
                    regs[wb.dst[4:2]][8*b +: 8] <= wb.data[8*b +: 8];
            end
        end
    end

endmodule

`default_nettype wire

/* logic/tlcs_core.sv */
// Core top level. Fetch fills the byte queue over AXI4-Lite, decode issues
// move commands, the register bank supplies the source operand and the move
// unit writes the sized result back. dbg_reg/dbg_data peek at any register.

`timescale 1ns/100ps
`default_nettype none

module tlcs_core #(
    parameter int          QUEUE_BYTES = 8,
    parameter logic [31:0] RESET_PC    = 32'h0
) (
    input  wire logic             clk,
    input  wire logic             rst,
    output tlcs_pkg::axi_ar_t     ar,
    output logic                  arvalid,
    input  wire logic             arready,
    input  wire tlcs_pkg::axi_r_t r,
    input  wire logic             rvalid,
    output logic                  rready,
    input  wire logic [2:0]       dbg_reg,
    output logic [31:0]           dbg_data,
    output logic                  insn_done
);

    import tlcs_pkg::*;

    logic [31:0] op;
    logic        op_ok;
    logic [1:0]  consumed;
    alu_cmd_t    cmd;
    wb_t         wb;
    logic [31:0] rd_data;

    op_fetch #(
        .QUEUE_BYTES (QUEUE_BYTES),
        .RESET_PC    (RESET_PC)
    ) u_fetch (
        .clk      (clk),
        .rst      (rst),
        .ar       (ar),
        .arvalid  (arvalid),
        .arready  (arready),
        .r        (r),
        .rvalid   (rvalid),
        .rready   (rready),
        .op       (op),
        .op_ok    (op_ok),
        .consumed (consumed)
    );

    insn_decode u_decode (
        .clk       (clk),
        .rst       (rst),
        .op        (op),
        .op_ok     (op_ok),
        .consumed  (consumed),
        .cmd       (cmd),
        .insn_done (insn_done)
    );

    reg_bank u_regs (
        .clk      (clk),
        .rst      (rst),
        .rd_code  (cmd.src),
        .rd_data  (rd_data),
        .wb       (wb),
        .dbg_reg  (dbg_reg),
        .dbg_data (dbg_data)
    );

    move_unit u_move (
        .clk     (clk),
        .rst     (rst),
        .cmd     (cmd),
        .rd_data (rd_data),
        .wb      (wb)
    );

endmodule

`default_nettype wire

/* logic/tlcs_pkg.sv */
// Shared types for the TLCS-900H style front end and register move path.
// Holds the decoder phase and move-unit operation enums, the operand width,
// the command, write-back and AXI4-Lite read channel structs, and the
// register code rules. Modules refer to it by scoped names in their headers
// and import it inside the body where they need more.

`default_nettype none

package tlcs_pkg;

    typedef enum logic [1:0] {
        PH_FETCH    = 2'd0,
        PH_EXEC     = 2'd1,
        PH_FILL_IMM = 2'd2
    } op_phase_e;

    typedef enum logic [1:0] {
        ALU_NOP  = 2'd0,
        ALU_MOVE = 2'd1
    } alu_op_e;

    // zz field of the opcode
    typedef enum logic [1:0] {
        W_BYTE = 2'd0,
        W_WORD = 2'd1,
        W_LONG = 2'd2
    } width_e;

    typedef logic [7:0] reg_code_t; // byte address, E0..FF

    typedef struct packed {
        alu_op_e     op;
        logic [31:0] imm;
        logic        use_imm;  // immediate instead of register operand
        reg_code_t   src;
        reg_code_t   dst;
        width_e      width;
        logic        valid;
    } alu_cmd_t;

    typedef struct packed {
        reg_code_t   dst;
        logic [31:0] data;     // already replicated across lanes
        width_e      width;
        logic        valid;
    } wb_t;

    typedef struct packed {
        logic [31:0] addr;
        logic [ 2:0] prot;
    } axi_ar_t;

    typedef struct packed {
        logic [31:0] data;
        logic [ 1:0] resp;
    } axi_r_t;

    // short 3-bit register field to byte address
    function automatic reg_code_t short_reg_code(input logic [2:0] r, input width_e w);
        if (w == W_BYTE)
            return {4'he, r[2:1], 1'b0, ~r[0]}; // W,A,B,C,D,E,H,L
        else if (r[2])
            return {4'hf, r[1:0], 2'b00};       // XIX..XSP
        else
            return {4'he, r[1:0], 2'b00};       // XWA..XHL
    endfunction

    // size field of LD R,# : 2 byte, 3 word, else long
    function automatic width_e imm_width(input logic [2:0] zzz);
        case (zzz)
            3'd2:    return W_BYTE;
            3'd3:    return W_WORD;
            default: return W_LONG;
        endcase
    endfunction

endpackage

`default_nettype wire

/* testbench/tb_core.sv */
// Testbench for the core. Models an AXI4-Lite instruction memory, runs short
// directed programs through the decoder and checks every register through the
// debug port. All programs run once without stalls, then again under heavy
// random AXI stalls against the same expected values.

`timescale 1ns/100ps
`default_nettype none

module tb_core;

    import tlcs_pkg::*;

    localparam int          CLK_PERIOD   = 100;
    localparam logic [31:0] RESET_PC     = 32'h0;
    localparam int          MEM_BYTES    = 256;
    localparam int          INSN_TIMEOUT = 1000;  // cycles per program
    localparam int          RUN_CYCLES   = 1100;  // bound for one test run
    localparam int          RUNS         = 10;    // five tests run twice

    logic        clk;
    logic        rst;
    axi_ar_t     ar;
    logic        arvalid;
    logic        arready;
    axi_r_t      r;
    logic        rvalid;
    logic        rready;
    logic [2:0]  dbg_reg;
    logic [31:0] dbg_data;
    logic        insn_done;

    logic [7:0]  mem [MEM_BYTES];
    logic [7:0]  code [$];       // program of the current test
    logic [31:0] exp_regs [8];   // XWA..XSP
    logic        heavy;          // heavy AXI stalls
    logic [15:0] lfsr;
    int          checks;
    int          errors;

    tlcs_core #(
        .QUEUE_BYTES (8),
        .RESET_PC    (RESET_PC)
    ) DUT (
        .clk       (clk),
        .rst       (rst),
        .ar        (ar),
        .arvalid   (arvalid),
        .arready   (arready),
        .r         (r),
        .rvalid    (rvalid),
        .rready    (rready),
        .dbg_reg   (dbg_reg),
        .dbg_data  (dbg_data),
        .insn_done (insn_done)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hb400) : (s >> 1); // galois taps 16,14,13,11
    endfunction

    task automatic draw(input int n, output int v);
        v = 0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_next(lfsr);
            v = (v << 1) | int'(lfsr[0]);
        end
    endtask

    // little endian word with NOPs past the end of the program
    function automatic logic [31:0] mem_word(input logic [31:0] addr);
        logic [31:0] off;
        logic [31:0] w;
        w = '0;
        for (int i = 0; i < 4; i++) begin
            off = addr - RESET_PC + 32'(i);
            if (off < MEM_BYTES)
                w[8*i +: 8] = mem[off[7:0]];
        end
        return w;
    endfunction

    initial begin : axi_memory
        logic        ar_fire;
        logic        r_fire;
        logic        in_reset;
        logic        busy;
        logic [31:0] ar_addr;
        logic [31:0] rd_addr;
        logic [31:0] exp_addr;
        int          wait_cnt;
        int          pick;
        arready  = 1'b0;
        rvalid   = 1'b0;
        r        = '0;
        busy     = 1'b0;
        rd_addr  = '0;
        exp_addr = RESET_PC;
        wait_cnt = 0;
        pick     = 0;
        lfsr     = 16'd99;
        forever begin
            @(posedge clk);
            ar_fire  = arvalid && arready;
            r_fire   = rvalid && rready;
            ar_addr  = ar.addr; // payload at the handshake edge
            in_reset = rst;
            #1;
            if (in_reset) begin
                busy     = 1'b0;
                arready  = 1'b0;
                rvalid   = 1'b0;
                exp_addr = RESET_PC;
            end else begin
                if (r_fire) begin
                    rvalid = 1'b0;
                    busy   = 1'b0;
                end
                if (ar_fire) begin
                    compare("ar.addr", ar_addr, exp_addr);
                    exp_addr = exp_addr + 32'd4; // sequential word fetch
                    busy     = 1'b1;
                    rd_addr  = ar_addr;
                    wait_cnt = 0;
                    if (heavy)
                        draw(3, wait_cnt); // 0..7 cycles of R latency
                end
                if (busy && !rvalid) begin
                    if (wait_cnt == 0) begin
                        rvalid = 1'b1;
                        r      = '{data: mem_word(rd_addr), resp: 2'b00};
                    end else begin
                        wait_cnt--;
                    end
                end
                if (heavy)
                    draw(2, pick); // ready one cycle in four
                arready = !busy && (!heavy || pick == 3);
            end
        end
    end

    function automatic string reg_name(input int i);
        case (i)
            0:       return "XWA";
            1:       return "XBC";
            2:       return "XDE";
            3:       return "XHL";
            4:       return "XIX";
            5:       return "XIY";
            6:       return "XIZ";
            default: return "XSP";
        endcase
    endfunction

    task automatic compare(input string name, input logic [31:0] got, input logic [31:0] want);
        checks++;
        if (got !== want) begin
            $display("FAILED at %0d ns: %s = %h, expected %h", $time, name, got, want);
            errors++;
        end
    endtask

    // reset with the program loaded and count finished instructions
    task automatic run_program(input int n_insns);
        int seen;
        int cycles;
        @(posedge clk);
        #1 rst = 1'b1;
        for (int i = 0; i < MEM_BYTES; i++)
            mem[i] = 8'h00;
        foreach (code[i])
            mem[i] = code[i];
        repeat (16) @(posedge clk);
        #1 rst = 1'b0;
        seen   = 0;
        cycles = 0;
        while (seen < n_insns && cycles < INSN_TIMEOUT) begin
            @(posedge clk);
            if (insn_done)
                seen++;
            cycles++;
        end
        if (seen < n_insns) begin
            $display("timeout: only %0d of %0d instructions completed", seen, n_insns);
            errors++;
        end
        repeat (3) @(posedge clk); // write-back lands two cycles after done
    endtask

    task automatic check_regs(input string tag);
        string mode;
        mode = heavy ? "stalled" : "plain";
        for (int i = 0; i < 8; i++) begin
            @(posedge clk);
            #1 dbg_reg = 3'(i);
            @(posedge clk);
            compare($sformatf("%s %s %s", mode, tag, reg_name(i)), dbg_data, exp_regs[i]);
        end
    endtask

    // byte loads of W,A,B,C,D,E,H,L into the low words of XWA..XHL
    task automatic test_byte_loads();
        code = '{8'h20, 8'h11, 8'h21, 8'h22, 8'h22, 8'h33, 8'h23, 8'h44,
                 8'h24, 8'h55, 8'h25, 8'h66, 8'h26, 8'h77, 8'h27, 8'h88};
        exp_regs = '{32'h00001122, 32'h00003344, 32'h00005566, 32'h00007788,
                     32'h0, 32'h0, 32'h0, 32'h0};
        run_program(8);
        check_regs("byte_imm");
    endtask

    task automatic test_wide_imm();
        code = '{8'h31, 8'h34, 8'h12,                      // XBC word
                 8'h45, 8'h78, 8'h56, 8'h34, 8'h12,        // XIY long
                 8'h37, 8'hcd, 8'hab,                      // XSP word
                 8'h40, 8'hef, 8'hbe, 8'had, 8'hde,        // XWA long
                 8'h43, 8'h44, 8'h33, 8'h22, 8'h11,        // XHL long
                 8'h33, 8'hbb, 8'haa};                     // XHL low word only
        exp_regs = '{32'hdeadbeef, 32'h00001234, 32'h0, 32'h1122aabb,
                     32'h0, 32'h12345678, 32'h0, 32'h0000abcd};
        run_program(6);
        check_regs("wide_imm");
    endtask

    task automatic test_reg_moves();
        code = '{8'h41, 8'hef, 8'hcd, 8'hab, 8'h89,        // XBC long
                 8'he8, 8'h99,                             // XWA <- XBC as long
                 8'hd9, 8'h8b,                             // XHL <- XBC as word
                 8'hc9, 8'h9a,                             // A <- B
                 8'hdc, 8'h98,                             // XIX <- XWA as word
                 8'hce, 8'h8f};                            // L <- H
        exp_regs = '{32'h89abcdcd, 32'h89abcdef, 32'h0, 32'h0000cdcd,
                     32'h0000cdcd, 32'h0, 32'h0, 32'h0};
        run_program(6);
        check_regs("reg_move");
    endtask

    task automatic test_small_imm();
        code = '{8'hc8, 8'had,                             // W <- 5
                 8'hda, 8'haf,                             // XDE <- 7
                 8'heb, 8'hab,                             // XHL <- 3
                 8'hef, 8'h03, 8'h78, 8'h56, 8'h34, 8'h12, // XSP long
                 8'hdd, 8'h03, 8'h22, 8'h11,               // XIY word
                 8'hca, 8'h03, 8'h5a};                     // B byte
        exp_regs = '{32'h00000500, 32'h00005a00, 32'h00000007, 32'h00000003,
                     32'h0, 32'h00001122, 32'h0, 32'h12345678};
        run_program(6);
        check_regs("prefix_imm");
    endtask

    // NOPs and unknown bytes between loads must keep the byte stream aligned
    task automatic test_nop_skip();
        code = '{8'h00, 8'h08, 8'h21, 8'h5c, 8'h80, 8'hc0,
                 8'hf9, 8'h00, 8'h0f, 8'h26, 8'ha5, 8'h00};
        exp_regs = '{32'h0000005c, 32'h0, 32'h0, 32'h0000a500,
                     32'h0, 32'h0, 32'h0, 32'h0};
        run_program(10);
        check_regs("nop_skip");
    endtask

    task automatic test_heavy_stalls();
        heavy = 1'b1;
        test_byte_loads();
        test_wide_imm();
        test_reg_moves();
        test_small_imm();
        test_nop_skip();
        heavy = 1'b0;
    endtask

    initial begin
        rst     = 1'b1;
        dbg_reg = 3'd0;
        heavy   = 1'b0;
        checks  = 0;
        errors  = 0;
        test_byte_loads();
        test_wide_imm();
        test_reg_moves();
        test_small_imm();
        test_nop_skip();
        test_heavy_stalls();
        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0)
            $display("NO ERRORS");
        else
            $display("ERRORS FOUND");
        $finish;
    end

    initial begin : watchdog
        #(RUNS * RUN_CYCLES * CLK_PERIOD);
        $display("timeout: simulation did not finish within %0d cycles", RUNS * RUN_CYCLES);
        $display("ERRORS FOUND");
        $finish;
    end

endmodule

`default_nettype wire

/* testbench/tb_core_properties.sv */
// Bound assertions. One instance sits in op_fetch and watches the AXI4-Lite
// read handshake and the queue fill; a second sits in reg_bank and watches
// the write-back destination. Unused ports of each instance are tied off.

`timescale 1ns/100ps
`default_nettype none

module tb_core_properties #(
    parameter int FILL_W = 4
) (
    input wire logic                clk,
    input wire logic                rst,
    input wire logic                arvalid,
    input wire logic                arready,
    input wire tlcs_pkg::axi_ar_t   ar,
    input wire logic                rvalid,
    input wire logic                rready,
    input wire logic [1:0]          consumed,
    input wire logic [FILL_W-1:0]   fill,
    input wire logic                wb_valid,
    input wire tlcs_pkg::reg_code_t wb_dst
);

    logic outstanding; // read accepted, R not yet seen

    always_ff @(posedge clk or posedge rst) begin
        if (rst)
            outstanding <= 1'b0;
        else if (arvalid && arready)
            outstanding <= 1'b1;
        else if (rvalid && rready)
            outstanding <= 1'b0;
    end

    ar_stable: assert property (@(posedge clk) disable iff (rst)
        arvalid && !arready |=> arvalid && $stable(ar))
        else $error("AR valid or payload changed before ready");

    one_read: assert property (@(posedge clk) disable iff (rst)
        arvalid && arready |-> !outstanding)
        else $error("second read issued while one is outstanding");

    consume_fill: assert property (@(posedge clk) disable iff (rst)
        FILL_W'(consumed) <= fill)
        else $error("decoder consumed more bytes than are queued");

    wb_dst_legal: assert property (@(posedge clk) disable iff (rst)
        wb_valid |-> wb_dst >= 8'he0)
        else $error("write-back destination below E0");

endmodule

bind op_fetch tb_core_properties #(.FILL_W(CW)) fetch_props (
    .clk      (clk),
    .rst      (rst),
    .arvalid  (arvalid),
    .arready  (arready),
    .ar       (ar),
    .rvalid   (rvalid),
    .rready   (rready),
    .consumed (consumed),
    .fill     (fill),
    .wb_valid (1'b0),
    .wb_dst   (8'he0)
);

bind reg_bank tb_core_properties #(.FILL_W(4)) bank_props (
    .clk      (clk),
    .rst      (rst),
    .arvalid  (1'b0),
    .arready  (1'b0),
    .ar       ('0),
    .rvalid   (1'b0),
    .rready   (1'b0),
    .consumed (2'd0),
    .fill     (4'd0),
    .wb_valid (wb.valid),
    .wb_dst   (wb.dst)
);

`default_nettype wire
